/* core6809_config.svh */
/*
 * Widths, reset values, condition-code bit positions and opcode values
 * shared by the 6809-style core. Include before any package or module.
 */
`ifndef CORE6809_CONFIG_SVH
`define CORE6809_CONFIG_SVH

// Bus widths
`define ADDR_W        16
`define DATA_W        8

// Reset vector and condition codes after reset (E F I set)
`define RESET_VECTOR  16'hFFFE
`define CC_RESET      8'hD0

// Condition-code bit positions
`define CC_E          7
`define CC_F          6
`define CC_H          5
`define CC_I          4
`define CC_N          3
`define CC_Z          2
`define CC_V          1
`define CC_C          0

// Opcodes that the core executes
`define OP_NOP        8'h12
`define OP_COMA       8'h43
`define OP_LSRA       8'h44
`define OP_ASRA       8'h47
`define OP_ASLA       8'h48
`define OP_INCA       8'h4C
`define OP_CLRA       8'h4F
`define OP_COMB       8'h53
`define OP_LSRB       8'h54
`define OP_ASRB       8'h57
`define OP_ASLB       8'h58
`define OP_INCB       8'h5C
`define OP_CLRB       8'h5F
`define OP_LDA_IMM    8'h86
`define OP_STA_DIR    8'h97
`define OP_LDB_IMM    8'hC6
`define OP_STB_DIR    8'hD7

`endif

/* core6809_pkg.sv */
/*
 * Shared types of the 6809-style core: decoder controls, ALU result
 * and the store request passed from the register block to the LSU.
 */
`include "core6809_config.svh"

package core6809_pkg;

  // --------------------------------------------------------------------------
  // Decoder outputs
  // --------------------------------------------------------------------------

  // Operation carried out in the execute cycle
  typedef enum logic [3:0] {
    ALU_NONE,
    ALU_CLR,
    ALU_INC,
    ALU_ASL,
    ALU_ASR,
    ALU_LSR,
    ALU_COM,
    ALU_LOAD,
    ALU_STORE
  } alu_op_e;

  // Addressing mode, decides the instruction length
  typedef enum logic [1:0] {
    AMODE_INH,    // One byte
    AMODE_IMM,    // Opcode plus data byte
    AMODE_DIR     // Opcode plus low address byte
  } amode_e;

  typedef struct packed {
    amode_e  amode;
    alu_op_e op;
    logic    sel_b;    // Targets B instead of A
  } dec_t;

  // --------------------------------------------------------------------------
  // Datapath records
  // --------------------------------------------------------------------------

  // Flags are N Z V C, same order as the low CC nibble
  typedef struct packed {
    logic [`DATA_W-1:0] value;
    logic [3:0]         flags;
  } alu_res_t;

  // One-cycle write strobe towards the LSU
  typedef struct packed {
    logic               valid;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
  } store_req_t;

endpackage

/* fetch_unit.sv */
/*
 * Instruction fetch: PC, instruction register and operand register.
 * Reads one byte per free bus cycle and flags the execute cycle.
 */
`timescale 1ns/1ps
`include "core6809_config.svh"

module fetch_unit import core6809_pkg::*; (
  input  logic               clk,
  input  logic               reset_b,
  input  logic [`DATA_W-1:0] data_in,
  input  logic               lsu_busy,
  input  logic               vec_valid,
  input  logic [`ADDR_W-1:0] vec_addr,
  input  dec_t               dec,
  output logic [`ADDR_W-1:0] pc,
  output logic [`DATA_W-1:0] ir,
  output logic [`DATA_W-1:0] operand,
  output logic               exec_valid
);

  // One-hot fetch states
  localparam logic [2:0] ST_WAIT    = 3'b001;
  localparam logic [2:0] ST_OPCODE  = 3'b010;
  localparam logic [2:0] ST_OPERAND = 3'b100;

  logic [2:0]         state_q;
  logic [2:0]         state_d;
  logic [`ADDR_W-1:0] pc_q;
  logic [`DATA_W-1:0] ir_q;
  logic [`DATA_W-1:0] operand_q;

  wire st_wait     = state_q[0];
  wire st_opcode   = state_q[1];
  wire st_operand  = state_q[2];

  // IR holds an opcode in OPCODE; its mode says what data_in is now
  wire has_operand = dec.amode != AMODE_INH;

  // --------------------------------------------------------------------------
  // Byte steering, all gated by a free bus
  // --------------------------------------------------------------------------
  wire first_op    = st_wait & ~lsu_busy;                  // First opcode at vector
  wire inh_done    = st_opcode & ~lsu_busy & ~has_operand; // Exec, next opcode in
  wire take_opnd   = st_opcode & ~lsu_busy & has_operand;  // Operand byte in
  wire opnd_done   = st_operand & ~lsu_busy;               // Exec, next opcode in

  wire load_ir     = first_op | inh_done | opnd_done;

  always_comb begin
    state_d = state_q;
    if (first_op | inh_done | opnd_done)
      state_d = ST_OPCODE;
    else if (take_opnd)
      state_d = ST_OPERAND;
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q <= ST_WAIT;
      pc_q    <= '0;
      ir_q    <= `OP_NOP;
    end else begin
      state_q <= state_d;
      // Vector load wins, then one step per byte read
      if (vec_valid)
        pc_q <= vec_addr;
      else if (!lsu_busy)
        pc_q <= pc_q + `ADDR_W'd1;
      if (load_ir)
        ir_q <= data_in;
    end
  end

  // Operand byte
  always_ff @(posedge clk) begin
    if (take_opnd)
      operand_q <= data_in;
  end

  assign pc         = pc_q;
  assign ir         = ir_q;
  assign operand    = operand_q;
  assign exec_valid = inh_done | opnd_done;

  onehot_state_a: assert property (@(posedge clk) disable iff (!reset_b)
    $onehot(state_q));

  // Vector lands while the LSU still owns the bus, before any opcode fetch
  vec_wait_a: assert property (@(posedge clk) disable iff (!reset_b)
    vec_valid |-> st_wait && lsu_busy);

endmodule

/* inst_decode.sv */
/*
 * Combinational opcode decoder. Maps IR to addressing mode, operation
 * and target accumulator; unknown opcodes become one-byte no-ops.
 */
`timescale 1ns/1ps
`include "core6809_config.svh"

module inst_decode import core6809_pkg::*; (
  input  logic [`DATA_W-1:0] ir,
  output dec_t               dec
);

  alu_op_e op;
  logic    sel_b;

  // Column groups of the opcode map
  wire grp_imm = (ir[7:4] == 4'h8) | (ir[7:4] == 4'hC);
  wire grp_dir = (ir[7:4] == 4'h9) | (ir[7:4] == 4'hD);

  // --------------------------------------------------------------------------
  // Kept opcodes
  // --------------------------------------------------------------------------
  always_comb begin
    op    = ALU_NONE;
    sel_b = 1'b0;
    case (ir)
      `OP_CLRA:    op = ALU_CLR;
      `OP_INCA:    op = ALU_INC;
      `OP_ASLA:    op = ALU_ASL;
      `OP_ASRA:    op = ALU_ASR;
      `OP_LSRA:    op = ALU_LSR;
      `OP_COMA:    op = ALU_COM;
      `OP_LDA_IMM: op = ALU_LOAD;
      `OP_STA_DIR: op = ALU_STORE;
      `OP_CLRB: begin
        op    = ALU_CLR;
        sel_b = 1'b1;
      end
      `OP_INCB: begin
        op    = ALU_INC;
        sel_b = 1'b1;
      end
      `OP_ASLB: begin
        op    = ALU_ASL;
        sel_b = 1'b1;
      end
      `OP_ASRB: begin
        op    = ALU_ASR;
        sel_b = 1'b1;
      end
      `OP_LSRB: begin
        op    = ALU_LSR;
        sel_b = 1'b1;
      end
      `OP_COMB: begin
        op    = ALU_COM;
        sel_b = 1'b1;
      end
      `OP_LDB_IMM: begin
        op    = ALU_LOAD;
        sel_b = 1'b1;
      end
      `OP_STB_DIR: begin
        op    = ALU_STORE;
        sel_b = 1'b1;
      end
      default: op = ALU_NONE;   // NOP and all dropped opcodes
    endcase
  end

  // Only loads and stores carry a second byte
  wire is_mem   = (op == ALU_LOAD) | (op == ALU_STORE);
  wire mode_imm = grp_imm & is_mem;
  wire mode_dir = grp_dir & is_mem;
  wire mode_inh = ~is_mem;

  assign dec.amode = mode_inh ? AMODE_INH : (mode_imm ? AMODE_IMM : AMODE_DIR);
  assign dec.op    = op;
  assign dec.sel_b = sel_b;

  // Memory opcodes must sit in an immediate or direct column
  amode_onehot_a: assert final ($isunknown(ir) || $onehot({mode_inh, mode_imm, mode_dir}));

endmodule

/* alu_unit.sv */
/*
 * Combinational 8-bit ALU. Each operation builds its own result and
 * N Z V C vector, and a final select picks the one asked for.
 */
`timescale 1ns/1ps
`include "core6809_config.svh"

module alu_unit import core6809_pkg::*; (
  input  alu_op_e            op,
  input  logic [`DATA_W-1:0] operand_a,
  input  logic [3:0]         flags_in,
  output alu_res_t           res
);

  // N and Z of any result byte
  function automatic logic [1:0] nz_of(input logic [`DATA_W-1:0] v);
    nz_of = {v[`DATA_W-1], ~|v};
  endfunction

  wire [`DATA_W-1:0] x    = operand_a;
  wire               v_in = flags_in[1];
  wire               c_in = flags_in[0];

  // --------------------------------------------------------------------------
  // Per-operation values
  // --------------------------------------------------------------------------
  wire [`DATA_W-1:0] inc_val = x + `DATA_W'd1;
  wire [`DATA_W-1:0] asl_val = {x[6:0], 1'b0};
  wire [`DATA_W-1:0] asr_val = {x[7], x[7:1]};   // Sign bit kept
  wire [`DATA_W-1:0] lsr_val = {1'b0, x[7:1]};
  wire [`DATA_W-1:0] com_val = ~x;

  // Signed overflow on INC only from +127
  wire inc_ovf = x == 8'h7F;

  // --------------------------------------------------------------------------
  // Result vectors, {value, N, Z, V, C}
  // --------------------------------------------------------------------------
  alu_res_t res_clr;
  alu_res_t res_inc;
  alu_res_t res_asl;
  alu_res_t res_asr;
  alu_res_t res_lsr;
  alu_res_t res_com;
  alu_res_t res_pass;
  alu_res_t res_none;

  assign res_clr  = {`DATA_W'h00, 2'b01, 1'b0, 1'b0};
  assign res_inc  = {inc_val, nz_of(inc_val), inc_ovf, c_in};
  assign res_asl  = {asl_val, nz_of(asl_val), x[7] ^ x[6], x[7]};
  assign res_asr  = {asr_val, nz_of(asr_val), v_in, x[0]};
  assign res_lsr  = {lsr_val, nz_of(lsr_val), v_in, x[0]};
  assign res_com  = {com_val, nz_of(com_val), 1'b0, 1'b1};
  // Loads and stores pass the byte through, V cleared
  assign res_pass = {x, nz_of(x), 1'b0, c_in};
  assign res_none = {x, flags_in};

  // Final select
  always_comb begin
    case (op)
      ALU_CLR:   res = res_clr;
      ALU_INC:   res = res_inc;
      ALU_ASL:   res = res_asl;
      ALU_ASR:   res = res_asr;
      ALU_LSR:   res = res_lsr;
      ALU_COM:   res = res_com;
      ALU_LOAD:  res = res_pass;
      ALU_STORE: res = res_pass;
      default:   res = res_none;
    endcase
  end

endmodule

/* acc_cc_regs.sv */
/*
 * Accumulators A and B and the condition-code register. Writes back the
 * ALU result on the execute strobe and raises direct-page store requests.
 */
`timescale 1ns/1ps
`include "core6809_config.svh"

module acc_cc_regs import core6809_pkg::*; (
  input  logic               clk,
  input  logic               reset_b,
  input  logic               exec_valid,
  input  dec_t               dec,
  input  logic [`DATA_W-1:0] operand,
  input  alu_res_t           res,
  output logic [`DATA_W-1:0] acc_sel,
  output logic [`DATA_W-1:0] cc,
  output store_req_t         store
);

  logic [`DATA_W-1:0] a_q;
  logic [`DATA_W-1:0] b_q;
  logic [`DATA_W-1:0] cc_q;
  logic [`DATA_W-1:0] cc_d;

  wire is_load   = dec.op == ALU_LOAD;
  wire is_store  = dec.op == ALU_STORE;
  // Everything but NONE and STORE lands in an accumulator
  wire wr_acc    = exec_valid & (dec.op != ALU_NONE) & ~is_store;
  wire wr_cc     = exec_valid & (dec.op != ALU_NONE);

  // ALU source, immediate byte on loads
  assign acc_sel = is_load ? operand : (dec.sel_b ? b_q : a_q);

  // E F H I are never touched here
  always_comb begin
    cc_d        = cc_q;
    cc_d[`CC_N] = res.flags[3];
    cc_d[`CC_Z] = res.flags[2];
    cc_d[`CC_V] = res.flags[1];
    cc_d[`CC_C] = res.flags[0];
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a_q  <= '0;
      b_q  <= '0;
      cc_q <= `CC_RESET;
    end else begin
      if (wr_acc && dec.sel_b)
        b_q <= res.value;
      if (wr_acc && !dec.sel_b)
        a_q <= res.value;
      if (wr_cc)
        cc_q <= cc_d;
    end
  end

  assign cc = cc_q;

  // Direct page fixed at zero
  assign store.addr  = {{(`ADDR_W - `DATA_W){1'b0}}, operand};
  assign store.valid = exec_valid & is_store;
  assign store.data  = res.value;

  // Every store stalls the next execute cycle
  store_exec_a: assert property (@(posedge clk) disable iff (!reset_b)
    store.valid |=> !exec_valid);

endmodule

/* lsu_unit.sv */
/*
 * Load/store unit. Reads the big-endian reset vector after reset, then
 * performs single-cycle byte writes for direct-mode stores.
 */
`timescale 1ns/1ps
`include "core6809_config.svh"

module lsu_unit import core6809_pkg::*; (
  input  logic               clk,
  input  logic               reset_b,
  input  logic [`DATA_W-1:0] data_in,
  input  store_req_t         store,
  output logic               lsu_busy,
  output logic [`ADDR_W-1:0] lsu_addr,
  output logic               data_rw_n,
  output logic [`DATA_W-1:0] data_out,
  output logic               vec_valid,
  output logic [`ADDR_W-1:0] vec_addr
);

  typedef enum logic [1:0] {
    ST_VEC_HI,
    ST_VEC_LO,
    ST_IDLE,
    ST_WRITE
  } lsu_state_e;

  localparam logic [`ADDR_W-1:0] VEC_HI_ADDR = `RESET_VECTOR;
  localparam logic [`ADDR_W-1:0] VEC_LO_ADDR = VEC_HI_ADDR + `ADDR_W'd1;

  lsu_state_e         state_q;
  lsu_state_e         state_d;
  logic [`DATA_W-1:0] vec_hi_q;    // High vector byte, staged
  logic [`ADDR_W-1:0] wr_addr_q;
  logic [`DATA_W-1:0] wr_data_q;

  // --------------------------------------------------------------------------
  // State sequencing
  // --------------------------------------------------------------------------
  always_comb begin
    case (state_q)
      ST_VEC_HI: state_d = ST_VEC_LO;
      ST_VEC_LO: state_d = ST_IDLE;
      ST_IDLE:   state_d = store.valid ? ST_WRITE : ST_IDLE;
      default:   state_d = ST_IDLE;   // Write takes one cycle
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b)
      state_q <= ST_VEC_HI;
    else
      state_q <= state_d;
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (state_q == ST_VEC_HI)
      vec_hi_q <= data_in;
    if (store.valid) begin
      wr_addr_q <= store.addr;
      wr_data_q <= store.data;
    end
  end

  // --------------------------------------------------------------------------
  // Bus side
  // --------------------------------------------------------------------------
  always_comb begin
    case (state_q)
      ST_VEC_HI: lsu_addr = VEC_HI_ADDR;
      ST_VEC_LO: lsu_addr = VEC_LO_ADDR;
      ST_WRITE:  lsu_addr = wr_addr_q;
      default:   lsu_addr = '0;
    endcase
  end

  assign lsu_busy  = state_q != ST_IDLE;
  assign data_rw_n = state_q != ST_WRITE;
  assign data_out  = (state_q == ST_WRITE) ? wr_data_q : '0;

  // Low byte comes straight off the bus
  assign vec_valid = state_q == ST_VEC_LO;
  assign vec_addr  = {vec_hi_q, data_in};

  // Only IDLE accepts a store, a strobe in any other state would be lost
  store_accept_a: assert property (@(posedge clk) disable iff (!reset_b)
    store.valid |-> state_q == ST_IDLE);

endmodule

/* core6809.sv */
/*
 * Top of the reduced 6809-style core. Connects fetch, decode, ALU,
 * accumulators and LSU to a single big-endian byte-wide memory bus.
 */
`timescale 1ns/1ps
`include "core6809_config.svh"

module core6809 import core6809_pkg::*; (
  input  logic               clk,
  input  logic               reset_b,
  output logic [`ADDR_W-1:0] addr,
  output logic               data_rw_n,
  input  logic [`DATA_W-1:0] data_in,
  output logic [`DATA_W-1:0] data_out,
  output logic [`DATA_W-1:0] cc
);

  dec_t               dec;
  alu_res_t           alu_res;
  store_req_t         store;

  logic [`ADDR_W-1:0] pc;
  logic [`ADDR_W-1:0] lsu_addr;
  logic [`ADDR_W-1:0] vec_addr;
  logic [`DATA_W-1:0] ir;
  logic [`DATA_W-1:0] operand;
  logic [`DATA_W-1:0] acc_sel;
  logic               lsu_busy;
  logic               vec_valid;
  logic               exec_valid;

  // LSU owns the bus whenever it is busy, PC otherwise
  assign addr = lsu_busy ? lsu_addr : pc;

  fetch_unit fetch_unit_inst (
    .clk        (clk),
    .reset_b    (reset_b),
    .data_in    (data_in),
    .lsu_busy   (lsu_busy),
    .vec_valid  (vec_valid),
    .vec_addr   (vec_addr),
    .dec        (dec),
    .pc         (pc),
    .ir         (ir),
    .operand    (operand),
    .exec_valid (exec_valid)
  );

  inst_decode inst_decode_inst (
    .ir  (ir),
    .dec (dec)
  );

  // ALU sees only the arithmetic flags N Z V C
  alu_unit alu_unit_inst (
    .op        (dec.op),
    .operand_a (acc_sel),
    .flags_in  (cc[`CC_N:`CC_C]),
    .res       (alu_res)
  );

  acc_cc_regs acc_cc_regs_inst (
    .clk        (clk),
    .reset_b    (reset_b),
    .exec_valid (exec_valid),
    .dec        (dec),
    .operand    (operand),
    .res        (alu_res),
    .acc_sel    (acc_sel),
    .cc         (cc),
    .store      (store)
  );

  lsu_unit lsu_unit_inst (
    .clk       (clk),
    .reset_b   (reset_b),
    .data_in   (data_in),
    .store     (store),
    .lsu_busy  (lsu_busy),
    .lsu_addr  (lsu_addr),
    .data_rw_n (data_rw_n),
    .data_out  (data_out),
    .vec_valid (vec_valid),
    .vec_addr  (vec_addr)
  );

endmodule

/* tb_core6809.sv */
/*
 * Testbench for the reduced 6809-style core. Loads the memory image and the
 * expected bus writes from core6809_stim.txt, runs the program from reset
 * and checks the reset-vector fetch and every direct-mode store.
 */
`timescale 1ns/1ps

module tb_core6809;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam int QUIET_CYCLES   = 64;
  localparam int MAX_TESTS      = 16;

  logic        clk;
  logic        reset_b;
  logic [15:0] addr;
  logic        data_rw_n;
  logic [7:0]  data_in;
  logic [7:0]  data_out;
  logic [7:0]  cc;

  // 64 KB memory model
  logic [7:0]  mem [0:65535];

  // Expected writes, program order
  logic [15:0] exp_addr [$];
  logic [7:0]  exp_data [$];
  logic [7:0]  exp_cc   [$];
  string       test_name  [0:MAX_TESTS-1];
  int          test_count [0:MAX_TESTS-1];
  int          num_tests;

  // Writes seen on the bus
  logic [15:0] obs_addr [$];
  logic [7:0]  obs_data [$];
  logic [7:0]  obs_cc   [$];

  int          err_count;
  int          tests_run;
  int          tests_failed;
  bit          image_ok;

  core6809 core6809_inst (
    .clk       (clk),
    .reset_b   (reset_b),
    .addr      (addr),
    .data_rw_n (data_rw_n),
    .data_in   (data_in),
    .data_out  (data_out),
    .cc        (cc)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Read data valid in the same cycle as addr
  assign data_in = mem[addr];

  // Write cycles, sampled mid-cycle
  always @(negedge clk) begin
    if (reset_b && data_rw_n === 1'b0) begin
      obs_addr.push_back(addr);
      obs_data.push_back(data_out);
      obs_cc.push_back(cc);
      mem[addr] = data_out;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string sig, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", sig, actual, expected);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int base_err);
    tests_run++;
    if (err_count == base_err) begin
      $display("PASS %s", name);
    end else begin
      $display("FAIL %s (%0d errors)", name, err_count - base_err);
      tests_failed++;
    end
  endtask

  // Memory image and expected writes from the stimulus file
  task automatic load_image();
    int               fd;
    int               r;
    int               i;
    int               cnt;
    string            tag;
    string            name;
    logic [15:0]      base;
    logic [15:0]      a;
    logic [7:0]       d;
    logic [7:0]       c;
    logic [8*128-1:0] skip_buf;
    // Fill stays below 0x80, so stray code never stores
    for (i = 0; i < 65536; i++) begin
      mem[i] = {1'b0, i[14:8] ^ i[6:0] ^ {5'b0, i[15], i[7]}};
    end
    num_tests = 0;
    fd = $fopen("core6809_stim.txt", "r");
    image_ok = (fd != 0);
    if (image_ok) begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "m") begin
          r = $fscanf(fd, "%h", base);
          for (i = 0; i < 8; i++) begin
            r = $fscanf(fd, "%h", d);
            mem[base + i] = d;
          end
        end else if (tag == "t") begin
          r = $fscanf(fd, "%s %d", name, cnt);
          if (num_tests < MAX_TESTS) begin
            test_name[num_tests]  = name;
            test_count[num_tests] = cnt;
            num_tests++;
          end
        end else if (tag == "w") begin
          r = $fscanf(fd, "%h %h %h", a, d, c);
          exp_addr.push_back(a);
          exp_data.push_back(d);
          exp_cc.push_back(c);
        end else begin
          // Comment line
          r = $fgets(skip_buf, fd);
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence, starts in the first cycle after reset
  // --------------------------------------------------------------------------
  task automatic run_tests();
    int          t;
    int          k;
    int          cycles;
    int          base_err;
    int          done_w;
    int          target;
    bit          timed_out;
    logic [15:0] boot_exp [0:2];
    // Vector bytes at FFFE/FFFF, big-endian
    base_err    = err_count;
    boot_exp[0] = 16'hFFFE;
    boot_exp[1] = 16'hFFFF;
    boot_exp[2] = {mem[16'hFFFE], mem[16'hFFFF]};
    for (k = 0; k < 3; k++) begin
      @(negedge clk);
      check_value($sformatf("addr in cycle %0d", k + 1), addr, boot_exp[k]);
      check_value("data_rw_n", {15'b0, data_rw_n}, 16'h0001);
      check_value("cc", {8'h00, cc}, 16'h00D0);
    end
    report_test("reset_vector", base_err);

    done_w    = 0;
    timed_out = 1'b0;
    for (t = 0; t < num_tests && !timed_out; t++) begin
      base_err = err_count;
      target   = done_w + test_count[t];
      cycles   = 0;
      while (obs_addr.size() < target && cycles < TIMEOUT_CYCLES) begin
        @(negedge clk);
        cycles++;
      end
      if (obs_addr.size() < target) begin
        $display("Timed out in test %s: %0d of %0d writes seen after %0d cycles",
                 test_name[t], obs_addr.size(), target, cycles);
        err_count++;
        timed_out = 1'b1;
      end else begin
        for (k = done_w; k < target; k++) begin
          check_value($sformatf("addr of write %0d", k), obs_addr[k], exp_addr[k]);
          check_value($sformatf("data_out of write %0d", k), {8'h00, obs_data[k]},
                      {8'h00, exp_data[k]});
          check_value($sformatf("cc of write %0d", k), {8'h00, obs_cc[k]},
                      {8'h00, exp_cc[k]});
        end
        done_w = target;
      end
      report_test(test_name[t], base_err);
    end

    // Program tail is NOPs and fill, the bus must stay quiet
    if (!timed_out) begin
      base_err = err_count;
      cycles   = 0;
      while (obs_addr.size() == done_w && cycles < QUIET_CYCLES) begin
        @(negedge clk);
        cycles++;
      end
      if (obs_addr.size() != done_w) begin
        $display("Unexpected extra write to 0x%h after the last expected write",
                 obs_addr[done_w]);
        err_count++;
      end
      report_test("no_extra_writes", base_err);
    end
  endtask

  initial begin
    reset_b      = 1'b0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    load_image();
    repeat (3) @(posedge clk);
    reset_b <= 1'b1;
    if (!image_ok) begin
      $display("Could not open the stimulus file core6809_stim.txt");
      tests_failed++;
    end else begin
      run_tests();
    end
    $display("Tests run: %0d, failed: %0d, check errors: %0d",
             tests_run, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* core6809_stim.txt */
# m <addr> <8 bytes>      memory image, hex, bytes from addr upward
# t <name> <count>        test name and its number of expected writes
# w <addr> <data> <cc>    expected write in program order, hex
m 1000 86 3C 97 10 C6 80 D7 11
m 1008 86 00 97 12 C6 FF D7 13
m 1010 86 7F 4C 97 20 5C D7 21
m 1018 43 97 22 5F D7 23 53 D7
m 1020 24 4F 97 25 86 C1 48 97
m 1028 30 86 41 48 97 31 C6 81
m 1030 57 D7 32 C6 02 57 D7 33
m 1038 86 01 44 97 34 C6 FE 54
m 1040 D7 35 86 A5 97 40 97 41
m 1048 D7 42 12 3D D7 43 8B 97
m 1050 44 19 12 C6 00 D7 45 97
m 1058 FF 12 12 12 12 12 12 12
m FFF8 12 12 12 12 12 12 10 00
t load_store 4
w 0010 3C D0
w 0011 80 D8
w 0012 00 D4
w 0013 FF D8
t clr_inc_com 6
w 0020 80 D8
w 0021 00 D4
w 0022 7F D1
w 0023 00 D4
w 0024 FF D9
w 0025 00 D4
t shifts 6
w 0030 82 D9
w 0031 82 D8
w 0032 C0 D9
w 0033 01 D0
w 0034 00 D5
w 0035 7F D0
t mixed 7
w 0040 A5 D8
w 0041 A5 D8
w 0042 7F D0
w 0043 7F D0
w 0044 A5 D8
w 0045 00 D4
w 00FF A5 D8

/* flist.f */
+incdir+.
core6809_pkg.sv
fetch_unit.sv
inst_decode.sv
alu_unit.sv
acc_cc_regs.sv
lsu_unit.sv
core6809.sv
tb_core6809.sv
